//--- Bender.yml
package:
  name: mips_core

sources:
  - src/mips_pkg.sv
  - src/fetch_stage.sv
  - src/decode_stage.sv
  - src/reg_file.sv
  - src/execute_stage.sv
  - src/mem_stage.sv
  - src/mips_core.sv
  - target: simulation
    files:
      - tb/mips_core_sva.sv
      - tb/tb_mips_core.sv

//--- list.f
src/mips_pkg.sv
src/fetch_stage.sv
src/decode_stage.sv
src/reg_file.sv
src/execute_stage.sv
src/mem_stage.sv
src/mips_core.sv
tb/mips_core_sva.sv
tb/tb_mips_core.sv

//--- src/decode_stage.sv
// instruction decoder, operand forwarding, load-use stall and decode-to-execute register
`timescale 1ns/10ps
module decode_stage (
	input  logic                clk,
	input  logic                arst_n_i,
	input  mips_pkg::word_t     id_inst_i,
	input  mips_pkg::word_t     id_pc_i,
	output mips_pkg::reg_addr_t rf_raddr1_o,
	output mips_pkg::reg_addr_t rf_raddr2_o,
	input  mips_pkg::word_t     rf_rdata1_i,
	input  mips_pkg::word_t     rf_rdata2_i,
	input  logic                ex_fwd_we_i,
	input  mips_pkg::reg_addr_t ex_fwd_waddr_i,
	input  mips_pkg::word_t     ex_fwd_wdata_i,
	input  logic                mem_fwd_we_i,
	input  mips_pkg::reg_addr_t mem_fwd_waddr_i,
	input  mips_pkg::word_t     mem_fwd_wdata_i,
	input  logic                wb_we_i,
	input  mips_pkg::reg_addr_t wb_waddr_i,
	input  mips_pkg::word_t     wb_wdata_i,
	input  logic                mem_stall_i,
	output logic                stall_o,
	output mips_pkg::alu_op_t   ex_alu_op_o,
	output mips_pkg::word_t     ex_opa_o,
	output mips_pkg::word_t     ex_opb_o,
	output mips_pkg::word_t     ex_store_data_o,
	output logic                ex_we_o,
	output logic                ex_load_o,
	output logic                ex_store_o,
	output mips_pkg::reg_addr_t ex_waddr_o,
	output mips_pkg::word_t     ex_pc_o
);
	import mips_pkg::*;

	logic [5:0] opcode;
	logic [5:0] funct;
	reg_addr_t  rs;
	reg_addr_t  rt;
	reg_addr_t  rd;
	word_t      imm_sext;
	word_t      imm_zext;
	word_t      rs_val;
	word_t      rt_val;
	alu_op_t    alu_op;
	word_t      opb;
	reg_addr_t  waddr;
	logic       we;
	logic       is_load;
	logic       is_store;
	logic       use_rs;
	logic       use_rt;
	logic       load_use;

	assign opcode   = id_inst_i[31:26];
	assign rs       = id_inst_i[25:21];
	assign rt       = id_inst_i[20:16];
	assign rd       = id_inst_i[15:11];
	assign funct    = id_inst_i[5:0];
	assign imm_sext = {{16{id_inst_i[15]}}, id_inst_i[15:0]};
	assign imm_zext = {16'h0000, id_inst_i[15:0]};

	assign rf_raddr1_o = rs;
	assign rf_raddr2_o = rt;

	// youngest producer first, register file last
	function automatic word_t fwd_operand(reg_addr_t src, word_t rf_val);
		if (ex_fwd_we_i && ex_fwd_waddr_i == src) begin
			return ex_fwd_wdata_i;
		end else if (mem_fwd_we_i && mem_fwd_waddr_i == src) begin
			return mem_fwd_wdata_i;
		end else if (wb_we_i && wb_waddr_i == src) begin
			return wb_wdata_i;
		end
		return rf_val;
	endfunction

	always_comb begin
		rs_val = fwd_operand(rs, rf_rdata1_i);
		rt_val = fwd_operand(rt, rf_rdata2_i);
	end

	always_comb begin
		alu_op   = ALU_ADD;
		opb      = imm_sext;
		waddr    = rt;
		we       = 1'b0;
		is_load  = 1'b0;
		is_store = 1'b0;
		use_rs   = 1'b0;
		use_rt   = 1'b0;
		case (opcode)
			OP_SPECIAL: begin
				opb    = rt_val;
				waddr  = rd;
				we     = 1'b1;
				use_rs = 1'b1;
				use_rt = 1'b1;
				case (funct)
					FN_ADDU: alu_op = ALU_ADD;
					FN_SUBU: alu_op = ALU_SUB;
					FN_AND:  alu_op = ALU_AND;
					FN_OR:   alu_op = ALU_OR;
					FN_XOR:  alu_op = ALU_XOR;
					FN_SLT:  alu_op = ALU_SLT;
					default: begin
						// unknown function retires as a nop
						we     = 1'b0;
						use_rs = 1'b0;
						use_rt = 1'b0;
					end
				endcase
			end
			OP_ADDIU: begin
				we     = 1'b1;
				use_rs = 1'b1;
			end
			OP_ORI: begin
				alu_op = ALU_OR;
				opb    = imm_zext;
				we     = 1'b1;
				use_rs = 1'b1;
			end
			OP_LUI: begin
				alu_op = ALU_LUI;
				opb    = imm_zext;
				we     = 1'b1;
			end
			OP_LW: begin
				we      = 1'b1;
				is_load = 1'b1;
				use_rs  = 1'b1;
			end
			OP_SW: begin
				is_store = 1'b1;
				use_rs   = 1'b1;
				use_rt   = 1'b1;
			end
			default: ;
		endcase
		// $0 is never written
		if (waddr == '0) begin
			we = 1'b0;
		end
	end

	// load result is not ready before the memory stage
	assign load_use = ex_load_o && ex_we_o &&
		((use_rs && ex_waddr_o == rs) || (use_rt && ex_waddr_o == rt));
	assign stall_o  = load_use || mem_stall_i;

	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			ex_alu_op_o     <= ALU_ADD;
			ex_opa_o        <= '0;
			ex_opb_o        <= '0;
			ex_store_data_o <= '0;
			ex_we_o         <= 1'b0;
			ex_load_o       <= 1'b0;
			ex_store_o      <= 1'b0;
			ex_waddr_o      <= '0;
			ex_pc_o         <= '0;
		end else if (!mem_stall_i) begin
			if (load_use) begin
				// bubble
				ex_we_o    <= 1'b0;
				ex_load_o  <= 1'b0;
				ex_store_o <= 1'b0;
			end else begin
				ex_alu_op_o     <= alu_op;
				ex_opa_o        <= rs_val;
				ex_opb_o        <= opb;
				ex_store_data_o <= rt_val;
				ex_we_o         <= we;
				ex_load_o       <= is_load;
				ex_store_o      <= is_store;
				ex_waddr_o      <= waddr;
				ex_pc_o         <= id_pc_i;
			end
		end
	end

endmodule

//--- src/execute_stage.sv
// ALU and execute-to-memory pipeline register
`timescale 1ns/10ps
module execute_stage (
	input  logic                clk,
	input  logic                arst_n_i,
	input  logic                mem_stall_i,
	input  mips_pkg::alu_op_t   ex_alu_op_i,
	input  mips_pkg::word_t     ex_opa_i,
	input  mips_pkg::word_t     ex_opb_i,
	input  mips_pkg::word_t     ex_store_data_i,
	input  logic                ex_we_i,
	input  logic                ex_load_i,
	input  logic                ex_store_i,
	input  mips_pkg::reg_addr_t ex_waddr_i,
	input  mips_pkg::word_t     ex_pc_i,
	output logic                fwd_we_o,
	output mips_pkg::reg_addr_t fwd_waddr_o,
	output mips_pkg::word_t     fwd_wdata_o,
	output mips_pkg::word_t     mem_result_o,
	output mips_pkg::word_t     mem_store_data_o,
	output mips_pkg::word_t     mem_pc_o,
	output logic                mem_we_o,
	output logic                mem_load_o,
	output logic                mem_store_o,
	output mips_pkg::reg_addr_t mem_waddr_o
);
	import mips_pkg::*;

	word_t alu_result;

	// loads and stores arrive as ALU_ADD, giving the address
	always_comb begin
		case (ex_alu_op_i)
			ALU_ADD: alu_result = ex_opa_i + ex_opb_i;
			ALU_SUB: alu_result = ex_opa_i - ex_opb_i;
			ALU_AND: alu_result = ex_opa_i & ex_opb_i;
			ALU_OR:  alu_result = ex_opa_i | ex_opb_i;
			ALU_XOR: alu_result = ex_opa_i ^ ex_opb_i;
			ALU_SLT: alu_result = {31'd0, $signed(ex_opa_i) < $signed(ex_opb_i)};
			ALU_LUI: alu_result = {ex_opb_i[15:0], 16'h0000};
			default: alu_result = '0;
		endcase
	end

	// forwarding to decode
	assign fwd_we_o    = ex_we_i;
	assign fwd_waddr_o = ex_waddr_i;
	assign fwd_wdata_o = alu_result;

	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			mem_result_o     <= '0;
			mem_store_data_o <= '0;
			mem_pc_o         <= '0;
			mem_we_o         <= 1'b0;
			mem_load_o       <= 1'b0;
			mem_store_o      <= 1'b0;
			mem_waddr_o      <= '0;
		end else if (!mem_stall_i) begin
			mem_result_o     <= alu_result;
			mem_store_data_o <= ex_store_data_i;
			mem_pc_o         <= ex_pc_i;
			mem_we_o         <= ex_we_i;
			mem_load_o       <= ex_load_i;
			mem_store_o      <= ex_store_i;
			mem_waddr_o      <= ex_waddr_i;
		end
	end

endmodule

//--- src/fetch_stage.sv
// program counter and fetch-to-decode pipeline register
`timescale 1ns/10ps
module fetch_stage #(
	parameter mips_pkg::word_t RESET_PC = mips_pkg::DEFAULT_RESET_PC
) (
	input  logic            clk,
	input  logic            arst_n_i,
	input  logic            stall_i,
	output mips_pkg::word_t inst_addr_o,
	input  mips_pkg::word_t inst_rdata_i,
	output mips_pkg::word_t id_inst_o,
	output mips_pkg::word_t id_pc_o
);
	import mips_pkg::*;

	word_t pc_q;

	// instruction memory answers in the same cycle
	assign inst_addr_o = pc_q;

	// no branches, so the pc only counts up
	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			pc_q <= RESET_PC;
		end else if (!stall_i) begin
			pc_q <= pc_q + INSTR_BYTES;
		end
	end

	// all-zero word is sll $0,$0,0 which decodes as a nop
	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			id_inst_o <= '0;
			id_pc_o   <= RESET_PC;
		end else if (!stall_i) begin
			id_inst_o <= inst_rdata_i;
			id_pc_o   <= pc_q;
		end
	end

endmodule

//--- src/mem_stage.sv
// data bus FSM, load result select and memory-to-writeback pipeline register
`timescale 1ns/10ps
module mem_stage (
	input  logic                clk,
	input  logic                arst_n_i,
	input  mips_pkg::word_t     mem_result_i,
	input  mips_pkg::word_t     mem_store_data_i,
	input  mips_pkg::word_t     mem_pc_i,
	input  logic                mem_we_i,
	input  logic                mem_load_i,
	input  logic                mem_store_i,
	input  mips_pkg::reg_addr_t mem_waddr_i,
	output logic                data_req_o,
	output logic                data_wr_o,
	output mips_pkg::word_t     data_addr_o,
	output mips_pkg::word_t     data_wdata_o,
	input  logic                data_addr_ok_i,
	input  logic                data_data_ok_i,
	input  mips_pkg::word_t     data_rdata_i,
	output logic                mem_stall_o,
	output logic                fwd_we_o,
	output mips_pkg::reg_addr_t fwd_waddr_o,
	output mips_pkg::word_t     fwd_wdata_o,
	output logic                wb_we_o,
	output mips_pkg::reg_addr_t wb_waddr_o,
	output mips_pkg::word_t     wb_wdata_o,
	output mips_pkg::word_t     wb_pc_o
);
	import mips_pkg::*;

	mem_state_e state_q;
	mem_state_e state_d;
	logic       is_mem;
	logic       done;
	word_t      result;

	assign is_mem = mem_load_i || mem_store_i;
	assign done   = (state_q == MEM_DATA) && data_data_ok_i;

	// held from arrival until the data_ok cycle
	assign mem_stall_o = is_mem && !done;

	always_comb begin
		state_d = state_q;
		case (state_q)
			MEM_IDLE: begin
				if (is_mem) begin
					state_d = MEM_ADDR;
				end
			end
			MEM_ADDR: begin
				if (data_addr_ok_i) begin
					state_d = MEM_DATA;
				end
			end
			MEM_DATA: begin
				if (data_data_ok_i) begin
					state_d = MEM_IDLE;
				end
			end
			default: state_d = MEM_IDLE;
		endcase
	end

	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			state_q <= MEM_IDLE;
		end else begin
			state_q <= state_d;
		end
	end

	// request fields come straight from the held EX/MEM register
	assign data_req_o   = (state_q == MEM_ADDR);
	assign data_wr_o    = mem_store_i;
	assign data_addr_o  = mem_result_i;
	assign data_wdata_o = mem_store_data_i;

	assign result = mem_load_i ? data_rdata_i : mem_result_i;

	assign fwd_we_o    = mem_we_i;
	assign fwd_waddr_o = mem_waddr_i;
	assign fwd_wdata_o = result;

	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			wb_we_o    <= 1'b0;
			wb_waddr_o <= '0;
			wb_wdata_o <= '0;
			wb_pc_o    <= '0;
		end else if (mem_stall_o) begin
			// bubble while waiting on the bus
			wb_we_o <= 1'b0;
		end else begin
			wb_we_o    <= mem_we_i;
			wb_waddr_o <= mem_waddr_i;
			wb_wdata_o <= result;
			wb_pc_o    <= mem_pc_i;
		end
	end

endmodule

//--- src/mips_core.sv
// five-stage MIPS32 subset core, wiring of the pipeline stages and register file
`timescale 1ns/10ps
module mips_core #(
	parameter mips_pkg::word_t RESET_PC = mips_pkg::DEFAULT_RESET_PC
) (
	input  logic                clk,
	input  logic                arst_n_i,
	output mips_pkg::word_t     inst_addr_o,
	input  mips_pkg::word_t     inst_rdata_i,
	output logic                data_req_o,
	output logic                data_wr_o,
	output mips_pkg::word_t     data_addr_o,
	output mips_pkg::word_t     data_wdata_o,
	input  logic                data_addr_ok_i,
	input  logic                data_data_ok_i,
	input  mips_pkg::word_t     data_rdata_i,
	output logic                wb_we_o,
	output mips_pkg::reg_addr_t wb_waddr_o,
	output mips_pkg::word_t     wb_wdata_o,
	output mips_pkg::word_t     wb_pc_o
);
	import mips_pkg::*;

	// fetch to decode
	word_t     id_inst;
	word_t     id_pc;
	logic      stall;

	// register file read ports
	reg_addr_t rf_raddr1;
	reg_addr_t rf_raddr2;
	word_t     rf_rdata1;
	word_t     rf_rdata2;

	// decode to execute
	alu_op_t   ex_alu_op;
	word_t     ex_opa;
	word_t     ex_opb;
	word_t     ex_store_data;
	logic      ex_we;
	logic      ex_load;
	logic      ex_store;
	reg_addr_t ex_waddr;
	word_t     ex_pc;

	// execute to memory
	word_t     mem_result;
	word_t     mem_store_data;
	word_t     mem_pc;
	logic      mem_we;
	logic      mem_load;
	logic      mem_store;
	reg_addr_t mem_waddr;
	logic      mem_stall;

	// forwarding paths back into decode
	logic      ex_fwd_we;
	reg_addr_t ex_fwd_waddr;
	word_t     ex_fwd_wdata;
	logic      mem_fwd_we;
	reg_addr_t mem_fwd_waddr;
	word_t     mem_fwd_wdata;

	fetch_stage #(.RESET_PC(RESET_PC)) u_fetch (
		.clk(clk), .arst_n_i(arst_n_i),
		.stall_i(stall),
		.inst_addr_o(inst_addr_o), .inst_rdata_i(inst_rdata_i),
		.id_inst_o(id_inst), .id_pc_o(id_pc)
	);

	decode_stage u_decode (
		.clk(clk), .arst_n_i(arst_n_i),
		.id_inst_i(id_inst), .id_pc_i(id_pc),
		.rf_raddr1_o(rf_raddr1), .rf_raddr2_o(rf_raddr2),
		.rf_rdata1_i(rf_rdata1), .rf_rdata2_i(rf_rdata2),
		.ex_fwd_we_i(ex_fwd_we), .ex_fwd_waddr_i(ex_fwd_waddr),
		.ex_fwd_wdata_i(ex_fwd_wdata),
		.mem_fwd_we_i(mem_fwd_we), .mem_fwd_waddr_i(mem_fwd_waddr),
		.mem_fwd_wdata_i(mem_fwd_wdata),
		.wb_we_i(wb_we_o), .wb_waddr_i(wb_waddr_o), .wb_wdata_i(wb_wdata_o),
		.mem_stall_i(mem_stall), .stall_o(stall),
		.ex_alu_op_o(ex_alu_op), .ex_opa_o(ex_opa), .ex_opb_o(ex_opb),
		.ex_store_data_o(ex_store_data),
		.ex_we_o(ex_we), .ex_load_o(ex_load), .ex_store_o(ex_store),
		.ex_waddr_o(ex_waddr), .ex_pc_o(ex_pc)
	);

	// written from the writeback register
	reg_file u_reg_file (
		.clk(clk), .arst_n_i(arst_n_i),
		.we_i(wb_we_o), .waddr_i(wb_waddr_o), .wdata_i(wb_wdata_o),
		.raddr1_i(rf_raddr1), .raddr2_i(rf_raddr2),
		.rdata1_o(rf_rdata1), .rdata2_o(rf_rdata2)
	);

	execute_stage u_execute (
		.clk(clk), .arst_n_i(arst_n_i),
		.mem_stall_i(mem_stall),
		.ex_alu_op_i(ex_alu_op), .ex_opa_i(ex_opa), .ex_opb_i(ex_opb),
		.ex_store_data_i(ex_store_data),
		.ex_we_i(ex_we), .ex_load_i(ex_load), .ex_store_i(ex_store),
		.ex_waddr_i(ex_waddr), .ex_pc_i(ex_pc),
		.fwd_we_o(ex_fwd_we), .fwd_waddr_o(ex_fwd_waddr), .fwd_wdata_o(ex_fwd_wdata),
		.mem_result_o(mem_result), .mem_store_data_o(mem_store_data),
		.mem_pc_o(mem_pc),
		.mem_we_o(mem_we), .mem_load_o(mem_load), .mem_store_o(mem_store),
		.mem_waddr_o(mem_waddr)
	);

	mem_stage u_mem (
		.clk(clk), .arst_n_i(arst_n_i),
		.mem_result_i(mem_result), .mem_store_data_i(mem_store_data),
		.mem_pc_i(mem_pc),
		.mem_we_i(mem_we), .mem_load_i(mem_load), .mem_store_i(mem_store),
		.mem_waddr_i(mem_waddr),
		.data_req_o(data_req_o), .data_wr_o(data_wr_o),
		.data_addr_o(data_addr_o), .data_wdata_o(data_wdata_o),
		.data_addr_ok_i(data_addr_ok_i), .data_data_ok_i(data_data_ok_i),
		.data_rdata_i(data_rdata_i),
		.mem_stall_o(mem_stall),
		.fwd_we_o(mem_fwd_we), .fwd_waddr_o(mem_fwd_waddr),
		.fwd_wdata_o(mem_fwd_wdata),
		.wb_we_o(wb_we_o), .wb_waddr_o(wb_waddr_o),
		.wb_wdata_o(wb_wdata_o), .wb_pc_o(wb_pc_o)
	);

endmodule

//--- src/mips_pkg.sv
// shared widths, vector types, MIPS32 opcode and function codes, ALU ops and memory FSM states
package mips_pkg;

	typedef logic [31:0] word_t;
	typedef logic [4:0]  reg_addr_t;
	typedef logic [2:0]  alu_op_t;

	// pc step and default boot address
	localparam word_t INSTR_BYTES      = 32'd4;
	localparam word_t DEFAULT_RESET_PC = 32'h0000_0000;

	// alu operations
	localparam alu_op_t ALU_ADD = 3'd0;
	localparam alu_op_t ALU_SUB = 3'd1;
	localparam alu_op_t ALU_AND = 3'd2;
	localparam alu_op_t ALU_OR  = 3'd3;
	localparam alu_op_t ALU_XOR = 3'd4;
	localparam alu_op_t ALU_SLT = 3'd5;
	localparam alu_op_t ALU_LUI = 3'd6;

	// major opcodes in inst[31:26]
	localparam logic [5:0] OP_SPECIAL = 6'h00;
	localparam logic [5:0] OP_ADDIU   = 6'h09;
	localparam logic [5:0] OP_ORI     = 6'h0d;
	localparam logic [5:0] OP_LUI     = 6'h0f;
	localparam logic [5:0] OP_LW      = 6'h23;
	localparam logic [5:0] OP_SW      = 6'h2b;

	// SPECIAL function field in inst[5:0]
	localparam logic [5:0] FN_ADDU = 6'h21;
	localparam logic [5:0] FN_SUBU = 6'h23;
	localparam logic [5:0] FN_AND  = 6'h24;
	localparam logic [5:0] FN_OR   = 6'h25;
	localparam logic [5:0] FN_XOR  = 6'h26;
	localparam logic [5:0] FN_SLT  = 6'h2a;

	// data bus handshake states
	typedef enum logic [1:0] {
		MEM_IDLE,
		MEM_ADDR,
		MEM_DATA
	} mem_state_e;

endpackage

//--- src/reg_file.sv
// 32-entry general purpose register file with two combinational read ports
`timescale 1ns/10ps
module reg_file (
	input  logic                clk,
	input  logic                arst_n_i,
	input  logic                we_i,
	input  mips_pkg::reg_addr_t waddr_i,
	input  mips_pkg::word_t     wdata_i,
	input  mips_pkg::reg_addr_t raddr1_i,
	input  mips_pkg::reg_addr_t raddr2_i,
	output mips_pkg::word_t     rdata1_o,
	output mips_pkg::word_t     rdata2_o
);
	import mips_pkg::*;

	word_t regs [32];

	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			for (int i = 0; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (we_i && waddr_i != '0) begin
			regs[waddr_i] <= wdata_i;
		end
	end

	// $0 reads as zero
	assign rdata1_o = (raddr1_i == '0) ? '0 : regs[raddr1_i];
	assign rdata2_o = (raddr2_i == '0) ? '0 : regs[raddr2_i];

endmodule

//--- tb/mips_core_sva.sv
// data bus, writeback port and reset assertions for mips_core, with its bind
`timescale 1ns/10ps
module mips_core_sva (
	input logic                clk,
	input logic                arst_n_i,
	input logic                data_req_i,
	input logic                data_wr_i,
	input mips_pkg::word_t     data_addr_i,
	input mips_pkg::word_t     data_wdata_i,
	input logic                data_addr_ok_i,
	input logic                wb_we_i,
	input mips_pkg::reg_addr_t wb_waddr_i
);

	// request and its fields held until the address is taken
	req_held: assert property (@(posedge clk) disable iff (!arst_n_i)
		data_req_i && !data_addr_ok_i |=> data_req_i && $stable(data_wr_i) &&
			$stable(data_addr_i) && $stable(data_wdata_i))
		else $error("data request or its fields changed before data_addr_ok_i");

	// $0 never shows on the writeback port
	no_wb_zero: assert property (@(posedge clk) disable iff (!arst_n_i)
		wb_we_i |-> wb_waddr_i != '0)
		else $error("wb_we_o asserted with wb_waddr_o equal to zero");

	quiet_in_reset: assert property (@(posedge clk)
		!arst_n_i |-> !data_req_i && !wb_we_i)
		else $error("data_req_o or wb_we_o high during reset");

	// first cycle after reset release
	quiet_after_reset: assert property (@(posedge clk)
		$rose(arst_n_i) |-> !data_req_i && !wb_we_i)
		else $error("data_req_o or wb_we_o high in the first cycle after reset");

endmodule

bind mips_core mips_core_sva u_sva (
	.clk(clk),
	.arst_n_i(arst_n_i),
	.data_req_i(data_req_o),
	.data_wr_i(data_wr_o),
	.data_addr_i(data_addr_o),
	.data_wdata_i(data_wdata_o),
	.data_addr_ok_i(data_addr_ok_i),
	.wb_we_i(wb_we_o),
	.wb_waddr_i(wb_waddr_o)
);

//--- tb/tb_mips_core.sv
// testbench for mips_core with instruction ROM, data bus model, ISA reference model and write checker
`timescale 1ns/10ps
module tb_mips_core;
	import mips_pkg::*;

	localparam word_t RESET_PC       = 32'h0000_0100;
	localparam int    TIMEOUT_CYCLES = 2000;
	localparam int    DRAIN_CYCLES   = 20;

	// bus model phases
	localparam int BUS_IDLE   = 0;
	localparam int BUS_ADDR   = 1;
	localparam int BUS_ACCEPT = 2;
	localparam int BUS_DATA   = 3;
	localparam int BUS_DONE   = 4;

	typedef struct packed {
		reg_addr_t waddr;
		word_t     wdata;
		word_t     pc;
	} wb_exp_t;

	typedef struct packed {
		word_t addr;
		word_t data;
	} store_exp_t;

	logic      clk            = 1'b0;
	logic      arst_n_i       = 1'b0;
	word_t     inst_addr_o;
	word_t     inst_rdata_i;
	logic      data_req_o;
	logic      data_wr_o;
	word_t     data_addr_o;
	word_t     data_wdata_o;
	logic      data_addr_ok_i = 1'b0;
	logic      data_data_ok_i = 1'b0;
	word_t     data_rdata_i   = '0;
	logic      wb_we_o;
	reg_addr_t wb_waddr_o;
	word_t     wb_wdata_o;
	word_t     wb_pc_o;

	word_t      rom [1024];
	word_t      prog [$];
	word_t      model_regs [32];
	word_t      model_mem [word_t];
	word_t      bus_mem [word_t];
	wb_exp_t    exp_q [$];
	store_exp_t store_q [$];
	integer     seed;
	int         bus_phase;
	int         bus_wait;
	word_t      bus_rdata;

	mips_core #(.RESET_PC(RESET_PC)) dut (
		.clk(clk), .arst_n_i(arst_n_i),
		.inst_addr_o(inst_addr_o), .inst_rdata_i(inst_rdata_i),
		.data_req_o(data_req_o), .data_wr_o(data_wr_o),
		.data_addr_o(data_addr_o), .data_wdata_o(data_wdata_o),
		.data_addr_ok_i(data_addr_ok_i), .data_data_ok_i(data_data_ok_i),
		.data_rdata_i(data_rdata_i),
		.wb_we_o(wb_we_o), .wb_waddr_o(wb_waddr_o),
		.wb_wdata_o(wb_wdata_o), .wb_pc_o(wb_pc_o)
	);

	always #5 clk = ~clk;

	// combinational instruction port with NOPs outside the first 4 KiB
	assign inst_rdata_i = (inst_addr_o[31:12] == '0) ? rom[inst_addr_o[11:2]] : '0;

	function automatic word_t r_type(input logic [5:0] fn, input reg_addr_t rd,
		input reg_addr_t rs, input reg_addr_t rt);
		return {OP_SPECIAL, rs, rt, rd, 5'd0, fn};
	endfunction

	function automatic word_t i_type(input logic [5:0] op, input reg_addr_t rt,
		input reg_addr_t rs, input logic [15:0] imm);
		return {op, rs, rt, imm};
	endfunction

	// contents of data memory never written
	function automatic word_t fill_word(input word_t addr);
		return {addr[15:0] ^ addr[31:16], ~addr[15:0]} ^ 32'h3c5a_0000;
	endfunction

	// in-order ISA model that queues every expected register write and store
	function automatic void ref_execute(input word_t inst, input word_t pc);
		logic [5:0] op;
		logic [5:0] fn;
		reg_addr_t  rs;
		reg_addr_t  rt;
		reg_addr_t  dst;
		word_t      a;
		word_t      b;
		word_t      simm;
		word_t      res;
		logic       wr;
		op   = inst[31:26];
		fn   = inst[5:0];
		rs   = inst[25:21];
		rt   = inst[20:16];
		a    = model_regs[rs];
		b    = model_regs[rt];
		simm = {{16{inst[15]}}, inst[15:0]};
		dst  = rt;
		res  = '0;
		wr   = 1'b1;
		case (op)
			OP_SPECIAL: begin
				dst = inst[15:11];
				case (fn)
					FN_ADDU: res = a + b;
					FN_SUBU: res = a - b;
					FN_AND:  res = a & b;
					FN_OR:   res = a | b;
					FN_XOR:  res = a ^ b;
					FN_SLT:  res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
					default: wr = 1'b0;
				endcase
			end
			OP_ADDIU: res = a + simm;
			OP_ORI:   res = a | {16'h0000, inst[15:0]};
			OP_LUI:   res = {inst[15:0], 16'h0000};
			OP_LW:    res = model_mem.exists(a + simm) ? model_mem[a + simm] : fill_word(a + simm);
			OP_SW: begin
				wr = 1'b0;
				model_mem[a + simm] = b;
				store_q.push_back('{addr: a + simm, data: b});
			end
			default: wr = 1'b0;
		endcase
		if (wr && dst != '0) begin
			model_regs[dst] = res;
			exp_q.push_back('{waddr: dst, wdata: res, pc: pc});
		end
	endfunction

	task automatic stop_on_error(input string msg);
		$display("Error at time %0d ns: %s", $time, msg);
		$display("FAIL: see errors above");
		$fatal(1, "simulation stopped on first error");
	endtask

	task automatic load_program();
		// ALU chain with dependencies at distance 1, 2 and 3
		prog.push_back(i_type(OP_LUI, 1, 0, 16'h1234));
		prog.push_back(i_type(OP_ORI, 1, 1, 16'h5678));
		prog.push_back(i_type(OP_ADDIU, 2, 0, 16'hfffd));
		prog.push_back(r_type(FN_ADDU, 3, 1, 2));
		prog.push_back(r_type(FN_SUBU, 4, 3, 1));
		prog.push_back(r_type(FN_AND, 5, 1, 4));
		prog.push_back(r_type(FN_OR, 6, 5, 2));
		prog.push_back(r_type(FN_XOR, 7, 6, 3));
		prog.push_back(r_type(FN_SLT, 8, 2, 1));
		prog.push_back(r_type(FN_SLT, 9, 1, 2));
		// store, load back, then load-use
		prog.push_back(i_type(OP_ADDIU, 10, 0, 16'h0200));
		prog.push_back(i_type(OP_SW, 7, 10, 16'h0000));
		prog.push_back(i_type(OP_LW, 11, 10, 16'h0000));
		prog.push_back(r_type(FN_ADDU, 12, 11, 1));
		prog.push_back(i_type(OP_SW, 12, 10, 16'h0004));
		prog.push_back(i_type(OP_LW, 13, 10, 16'h0004));
		prog.push_back(i_type(OP_LW, 14, 10, 16'h0008));
		prog.push_back(r_type(FN_XOR, 15, 13, 14));
		// no write for $0 or unknown encodings
		prog.push_back(i_type(OP_ADDIU, 0, 1, 16'h0005));
		prog.push_back(32'hfc00_0000);
		prog.push_back(r_type(6'h3f, 16, 1, 2));
		prog.push_back(i_type(OP_ORI, 16, 15, 16'hffff));
		prog.push_back(i_type(OP_SW, 16, 10, 16'hfffc));
		prog.push_back(i_type(OP_LW, 17, 10, 16'hfffc));
		prog.push_back(i_type(OP_SW, 17, 10, 16'h0010));
		prog.push_back(r_type(FN_ADDU, 18, 17, 17));
		prog.push_back(i_type(OP_LW, 19, 10, 16'h0010));
		prog.push_back(r_type(FN_SUBU, 20, 19, 18));
		for (int i = 0; i < 1024; i++) begin
			rom[i] = '0;
		end
		for (int i = 0; i < prog.size(); i++) begin
			rom[(RESET_PC >> 2) + i] = prog[i];
		end
	endtask

	initial begin
		int cycles;
		seed = 32'h4d29;
		for (int i = 0; i < 32; i++) begin
			model_regs[i] = '0;
		end
		load_program();
		for (int i = 0; i < prog.size(); i++) begin
			ref_execute(prog[i], RESET_PC + 4 * i);
		end
		repeat (3) @(posedge clk);
		assert (inst_addr_o == RESET_PC)
			else stop_on_error($sformatf("inst_addr_o %h in reset, expected %h",
				inst_addr_o, RESET_PC));
		arst_n_i <= 1'b1;
		cycles = 0;
		while (exp_q.size() != 0 || store_q.size() != 0) begin
			@(posedge clk);
			cycles++;
			assert (cycles <= TIMEOUT_CYCLES)
				else stop_on_error("timed out waiting for the expected writes and stores");
		end
		// quiet window where trailing NOPs must not write
		repeat (DRAIN_CYCLES) @(posedge clk);
		$display("PASS: all tests");
		$finish;
	end

	always @(posedge clk) begin : check_wb
		wb_exp_t head;
		if (arst_n_i && wb_we_o) begin
			assert (exp_q.size() != 0)
				else stop_on_error($sformatf("unexpected write of %h to $%0d", wb_wdata_o, wb_waddr_o));
			head = exp_q.pop_front();
			assert (wb_pc_o == head.pc)
				else stop_on_error($sformatf("wb_pc_o %h, expected %h", wb_pc_o, head.pc));
			assert (wb_waddr_o == head.waddr)
				else stop_on_error($sformatf("wb_waddr_o %0d at pc %h, expected %0d",
					wb_waddr_o, head.pc, head.waddr));
			assert (wb_wdata_o == head.wdata)
				else stop_on_error($sformatf("wb_wdata_o %h at pc %h, expected %h",
					wb_wdata_o, head.pc, head.wdata));
		end
	end

	// data memory with 0 to 3 extra cycles on each handshake
	always @(posedge clk or negedge arst_n_i) begin : bus_model
		store_exp_t st;
		if (!arst_n_i) begin
			data_addr_ok_i <= 1'b0;
			data_data_ok_i <= 1'b0;
			bus_phase = BUS_IDLE;
			bus_wait  = 0;
		end else begin
			data_addr_ok_i <= 1'b0;
			data_data_ok_i <= 1'b0;
			case (bus_phase)
				BUS_IDLE: begin
					if (data_req_o) begin
						bus_wait = $unsigned($random(seed)) % 4;
						bus_phase = BUS_ADDR;
						if (bus_wait == 0) begin
							data_addr_ok_i <= 1'b1;
							bus_phase = BUS_ACCEPT;
						end
					end
				end
				BUS_ADDR: begin
					bus_wait--;
					if (bus_wait == 0) begin
						data_addr_ok_i <= 1'b1;
						bus_phase = BUS_ACCEPT;
					end
				end
				BUS_ACCEPT: begin
					// address phase ends on this edge
					assert (data_req_o)
						else stop_on_error("data_req_o dropped before data_addr_ok_i");
					if (data_wr_o) begin
						assert (store_q.size() != 0)
							else stop_on_error($sformatf("unexpected store to %h", data_addr_o));
						st = store_q.pop_front();
						assert (data_addr_o == st.addr)
							else stop_on_error($sformatf("store address %h, expected %h",
								data_addr_o, st.addr));
						assert (data_wdata_o == st.data)
							else stop_on_error($sformatf("store data %h, expected %h",
								data_wdata_o, st.data));
						bus_mem[data_addr_o] = data_wdata_o;
					end else begin
						bus_rdata = bus_mem.exists(data_addr_o) ? bus_mem[data_addr_o]
							: fill_word(data_addr_o);
					end
					bus_wait = $unsigned($random(seed)) % 4;
					bus_phase = BUS_DATA;
					if (bus_wait == 0) begin
						data_data_ok_i <= 1'b1;
						data_rdata_i   <= bus_rdata;
						bus_phase = BUS_DONE;
					end
				end
				BUS_DATA: begin
					bus_wait--;
					if (bus_wait == 0) begin
						data_data_ok_i <= 1'b1;
						data_rdata_i   <= bus_rdata;
						bus_phase = BUS_DONE;
					end
				end
				default: bus_phase = BUS_IDLE;
			endcase
		end
	end

endmodule
